// ==== Makefile ====
# Verilator build of the I2S/DMA register block testbench
TOP = tb_i2s_dma_regs

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps -f verilog.f --top-module $(TOP)

# exit status of the simulation is the test result
run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== i2s_dma_ctrl_regs.sv ====
/*
 * control registers of the I2S receive path
 * i2s and filter enables, fifo flush, dma enable, count and start
 */
`timescale 1ns/100ps

module i2s_dma_ctrl_regs
	import i2s_dma_pkg::*;
(
	input  logic                  WBs_CLK_i,
	input  logic                  WBs_RST_i,
	input  logic [WB_DAT_W-1:0]   wbs_dat_i,
	input  logic                  wr_ctrl_i,
	input  logic                  wr_flush_i,
	input  logic                  wr_dma_en_i,
	input  logic                  wr_dma_cnt_i,
	input  logic                  wr_fir_i,
	input  logic                  i2s_dis_i,
	input  logic                  dma_clr_i,
	input  logic [FIFO_LVL_W-1:0] fifo_level_i,
	output logic                  i2s_en_o,
	output logic                  fir_en_o,
	output logic                  fifo_flush_o,
	output logic                  dma_en_o,
	output logic [FIFO_LVL_W-1:0] dma_cnt_o,
	output logic                  dma_start_o,
	output logic                  dat_avl_o
);

	// ------------------------------
	// host control bits
	// ------------------------------
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
	begin
		if (WBs_RST_i)
		begin
			i2s_en_o     <= 1'b0;
			fir_en_o     <= 1'b0;
			fifo_flush_o <= 1'b0;
			dma_en_o     <= 1'b0;
			dma_cnt_o    <= DMA_CNT_RST;
		end
		else
		begin
			// host write wins over the hardware disable
			if (wr_ctrl_i)
				i2s_en_o <= wbs_dat_i[CTRL_I2S_EN_BIT];
			else if (i2s_dis_i)
				i2s_en_o <= 1'b0;

			if (wr_fir_i)
				fir_en_o <= wbs_dat_i[FIR_EN_BIT];

			// flush lasts one cycle
			if (wr_flush_i)
				fifo_flush_o <= wbs_dat_i[FLUSH_BIT];
			else
				fifo_flush_o <= 1'b0;

			// dma engine clears its own enable when a transfer ends
			if (wr_dma_en_i)
				dma_en_o <= wbs_dat_i[DMA_EN_BIT];
			else if (dma_clr_i)
				dma_en_o <= 1'b0;

			if (wr_dma_cnt_i)
				dma_cnt_o <= wbs_dat_i[FIFO_LVL_W-1:0];
		end
	end

	// ------------------------------
	// threshold compare
	// ------------------------------
	// enough samples for one dma burst
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
	begin
		if (WBs_RST_i)
			dat_avl_o <= 1'b0;
		else
			dat_avl_o <= (fifo_level_i >= dma_cnt_o);
	end

	// request only while the host allows dma
	assign dma_start_o = dat_avl_o & dma_en_o;

endmodule

// ==== i2s_dma_fifo_reader.sv ====
/*
 * decimated-data fifo reader
 * pops the fall-through fifo and pairs two samples into one word
 */
`timescale 1ns/100ps

module i2s_dma_fifo_reader
	import i2s_dma_pkg::*;
(
	input  logic                WBs_CLK_i,
	input  logic                WBs_RST_i,
	input  logic                fifo_rd_phase_i,
	input  logic                fifo_empty_i,
	input  logic [SAMPLE_W-1:0] fifo_dat_i,
	output logic                fifo_pop_o,
	output logic [WB_DAT_W-1:0] fifo_word_o
);

	// newest sample on top
	logic [SAMPLE_W-1:0] smp_hi;
	logic [SAMPLE_W-1:0] smp_lo;

	// ------------------------------
	// pop
	// ------------------------------
	// one pop per read phase cycle
	// never pop an empty fifo
	assign fifo_pop_o = fifo_rd_phase_i & ~fifo_empty_i;

	// ------------------------------
	// sample pair
	// ------------------------------
	// head of fifo is valid before the pop, take it at the edge
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
	begin
		if (WBs_RST_i)
		begin
			smp_hi <= '0;
			smp_lo <= '0;
		end
		else if (fifo_pop_o)
		begin
			smp_hi <= fifo_dat_i;
			// older sample moves down
			smp_lo <= smp_hi;
		end
	end

	// second popped sample above the first
	assign fifo_word_o = {smp_hi, smp_lo};

endmodule

// ==== i2s_dma_irq_bit.sv ====
/*
 * one sticky interrupt status bit with its enable
 */
`timescale 1ns/100ps

module i2s_dma_irq_bit (
	input  logic WBs_CLK_i,
	input  logic WBs_RST_i,
	input  logic set_i,
	input  logic sts_wr_i,
	input  logic sts_bit_i,
	input  logic en_wr_i,
	input  logic en_bit_i,
	output logic sts_o,
	output logic en_o
);

	// status holds until the host writes 0
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
	begin
		if (WBs_RST_i)
			sts_o <= 1'b0;
		else if (set_i)
			// event beats a clearing write in the same cycle
			sts_o <= 1'b1;
		else if (sts_wr_i)
			sts_o <= sts_bit_i;
	end

	// enable is plain read/write
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
	begin
		if (WBs_RST_i)
			en_o <= 1'b0;
		else if (en_wr_i)
			en_o <= en_bit_i;
	end

endmodule

// ==== i2s_dma_pkg.sv ====
/*
 * I2S receive / DMA register block shared definitions
 * bus widths, register map, bit positions and reset values
 */
package i2s_dma_pkg;

	// ------------------------------
	// bus and data widths
	// ------------------------------
	localparam int WB_ADR_W   = 10;
	localparam int WB_DAT_W   = 32;
	localparam int WB_BSTB_W  = 4;
	localparam int SAMPLE_W   = 16;
	localparam int FIFO_LVL_W = 9;

	// ------------------------------
	// register map
	// ------------------------------
	localparam logic [WB_ADR_W-1:0] ADR_CTRL       = 'h0;
	localparam logic [WB_ADR_W-1:0] ADR_IRQ_STS    = 'h2;
	localparam logic [WB_ADR_W-1:0] ADR_IRQ_EN     = 'h3;
	localparam logic [WB_ADR_W-1:0] ADR_FIFO_STS   = 'h4;
	localparam logic [WB_ADR_W-1:0] ADR_FIFO_DAT   = 'h5;
	localparam logic [WB_ADR_W-1:0] ADR_FIFO_FLUSH = 'h7;
	localparam logic [WB_ADR_W-1:0] ADR_DMA_EN     = 'h8;
	localparam logic [WB_ADR_W-1:0] ADR_DMA_STS    = 'h9;
	localparam logic [WB_ADR_W-1:0] ADR_DMA_CNT    = 'hA;
	localparam logic [WB_ADR_W-1:0] ADR_FIR_CTRL   = 'hC;

	// single-bit control fields, all in bit 0 of their register
	localparam int CTRL_I2S_EN_BIT = 0;
	localparam int FIR_EN_BIT      = 0;
	localparam int FLUSH_BIT       = 0;
	localparam int DMA_EN_BIT      = 0;

	// ------------------------------
	// interrupt status / enable
	// ------------------------------
	localparam int IRQ_W         = 4;
	localparam int IRQ_NUM       = 3;
	localparam int IRQ_DMA_DONE  = 0;
	localparam int IRQ_DECI_DONE = 1;
	// level bit, read only
	localparam int IRQ_DAT_AVL   = 2;
	localparam int IRQ_I2S_DIS   = 3;

	// positions of the sticky bits, in generate loop order
	localparam int IRQ_POS [IRQ_NUM] = '{IRQ_DMA_DONE, IRQ_DECI_DONE, IRQ_I2S_DIS};

	// fifo status fields, level sits in the low bits
	localparam int FIFO_STS_EMPTY = 16;
	localparam int FIFO_STS_FULL  = 17;

	// dma status fields
	localparam int DMA_STS_BUSY   = 0;
	localparam int DMA_STS_ACTIVE = 1;
	localparam int DMA_STS_REQ    = 2;
	localparam int DMA_STS_START  = 3;

	// reset values
	localparam logic [FIFO_LVL_W-1:0] DMA_CNT_RST = 'd4;

endpackage

// ==== i2s_dma_rd_mux.sv ====
/*
 * read data mux of the I2S/DMA register block
 * unmapped addresses return zero
 */
`timescale 1ns/100ps

module i2s_dma_rd_mux
	import i2s_dma_pkg::*;
(
	input  logic [WB_ADR_W-1:0]   wbs_adr_i,
	input  logic                  i2s_en_i,
	input  logic                  fir_en_i,
	input  logic                  fifo_flush_i,
	input  logic                  dma_en_i,
	input  logic [FIFO_LVL_W-1:0] dma_cnt_i,
	input  logic                  dma_start_i,
	input  logic [IRQ_W-1:0]      irq_sts_i,
	input  logic [IRQ_W-1:0]      irq_en_i,
	input  logic                  fifo_full_i,
	input  logic                  fifo_empty_i,
	input  logic [FIFO_LVL_W-1:0] fifo_level_i,
	input  logic [WB_DAT_W-1:0]   fifo_word_i,
	input  logic                  dma_busy_i,
	input  logic                  dma_active_i,
	input  logic                  dma_req_i,
	output logic [WB_DAT_W-1:0]   wbs_dat_o
);

	// address is stable a cycle before ack so no output register
	always_comb
	begin
		wbs_dat_o = '0;
		case (wbs_adr_i)
			ADR_CTRL:       wbs_dat_o[CTRL_I2S_EN_BIT] = i2s_en_i;
			ADR_IRQ_STS:    wbs_dat_o[IRQ_W-1:0] = irq_sts_i;
			ADR_IRQ_EN:     wbs_dat_o[IRQ_W-1:0] = irq_en_i;
			ADR_FIFO_STS:
			begin
				wbs_dat_o[FIFO_STS_FULL]    = fifo_full_i;
				wbs_dat_o[FIFO_STS_EMPTY]   = fifo_empty_i;
				wbs_dat_o[FIFO_LVL_W-1:0]   = fifo_level_i;
			end
			// two samples from the reader
			ADR_FIFO_DAT:   wbs_dat_o = fifo_word_i;
			// self clearing, normally reads 0
			ADR_FIFO_FLUSH: wbs_dat_o[FLUSH_BIT] = fifo_flush_i;
			ADR_DMA_EN:     wbs_dat_o[DMA_EN_BIT] = dma_en_i;
			ADR_DMA_STS:
			begin
				wbs_dat_o[DMA_STS_BUSY]   = dma_busy_i;
				wbs_dat_o[DMA_STS_ACTIVE] = dma_active_i;
				wbs_dat_o[DMA_STS_REQ]    = dma_req_i;
				wbs_dat_o[DMA_STS_START]  = dma_start_i;
			end
			ADR_DMA_CNT:    wbs_dat_o[FIFO_LVL_W-1:0] = dma_cnt_i;
			ADR_FIR_CTRL:   wbs_dat_o[FIR_EN_BIT] = fir_en_i;
			default:        wbs_dat_o = '0;
		endcase
	end

endmodule

// ==== i2s_dma_regs_top.sv ====
/*
 * I2S receive / DMA host register block, Wishbone slave
 * decode, control registers, interrupt bits, fifo reader and read mux
 */
`timescale 1ns/100ps

module i2s_dma_regs_top
	import i2s_dma_pkg::*;
(
	// wishbone
	input  logic                  WBs_CLK_i,
	input  logic                  WBs_RST_i,
	input  logic [WB_ADR_W-1:0]   wbs_adr_i,
	input  logic                  wbs_cyc_i,
	input  logic                  wbs_stb_i,
	input  logic                  wbs_we_i,
	input  logic [WB_BSTB_W-1:0]  wbs_byte_stb_i,
	input  logic [WB_DAT_W-1:0]   wbs_dat_i,
	output logic [WB_DAT_W-1:0]   wbs_dat_o,
	output logic                  wbs_ack_o,
	// i2s and decimation filter
	input  logic                  i2s_dis_i,
	output logic                  i2s_en_o,
	output logic                  fir_en_o,
	input  logic                  fir_done_i,
	// decimated-data fifo
	input  logic [SAMPLE_W-1:0]   fifo_dat_i,
	input  logic                  fifo_empty_i,
	input  logic                  fifo_full_i,
	input  logic [FIFO_LVL_W-1:0] fifo_level_i,
	output logic                  fifo_pop_o,
	output logic                  fifo_flush_o,
	// dma engine
	input  logic                  dma_done_i,
	input  logic                  dma_clr_i,
	input  logic                  dma_busy_i,
	input  logic                  dma_active_i,
	input  logic                  dma_req_i,
	output logic                  dma_start_o,
	output logic [FIFO_LVL_W-1:0] dma_cnt_o,
	// interrupts
	output logic [IRQ_W-1:0]      irq_sts_o,
	output logic [IRQ_W-1:0]      irq_en_o
);

	// write strobes
	logic wr_ctrl;
	logic wr_irq_sts;
	logic wr_irq_en;
	logic wr_flush;
	logic wr_dma_en;
	logic wr_dma_cnt;
	logic wr_fir;
	logic fifo_rd_phase;
	logic dma_en;
	logic dat_avl;
	logic [WB_DAT_W-1:0] fifo_word;
	// sticky events in IRQ_POS order
	logic [IRQ_NUM-1:0]  irq_evt;

	// ------------------------------
	// bus decode
	// ------------------------------
	i2s_dma_wb_decode u_wb_decode (
		.WBs_CLK_i       (WBs_CLK_i),
		.WBs_RST_i       (WBs_RST_i),
		.wbs_adr_i       (wbs_adr_i),
		.wbs_cyc_i       (wbs_cyc_i),
		.wbs_stb_i       (wbs_stb_i),
		.wbs_we_i        (wbs_we_i),
		.wbs_byte_stb_i  (wbs_byte_stb_i),
		.wr_ctrl_o       (wr_ctrl),
		.wr_irq_sts_o    (wr_irq_sts),
		.wr_irq_en_o     (wr_irq_en),
		.wr_flush_o      (wr_flush),
		.wr_dma_en_o     (wr_dma_en),
		.wr_dma_cnt_o    (wr_dma_cnt),
		.wr_fir_o        (wr_fir),
		.fifo_rd_phase_o (fifo_rd_phase),
		.wbs_ack_o       (wbs_ack_o)
	);

	i2s_dma_ctrl_regs u_ctrl_regs (
		.WBs_CLK_i    (WBs_CLK_i),
		.WBs_RST_i    (WBs_RST_i),
		.wbs_dat_i    (wbs_dat_i),
		.wr_ctrl_i    (wr_ctrl),
		.wr_flush_i   (wr_flush),
		.wr_dma_en_i  (wr_dma_en),
		.wr_dma_cnt_i (wr_dma_cnt),
		.wr_fir_i     (wr_fir),
		.i2s_dis_i    (i2s_dis_i),
		.dma_clr_i    (dma_clr_i),
		.fifo_level_i (fifo_level_i),
		.i2s_en_o     (i2s_en_o),
		.fir_en_o     (fir_en_o),
		.fifo_flush_o (fifo_flush_o),
		.dma_en_o     (dma_en),
		.dma_cnt_o    (dma_cnt_o),
		.dma_start_o  (dma_start_o),
		.dat_avl_o    (dat_avl)
	);

	// ------------------------------
	// interrupt bits
	// ------------------------------
	assign irq_evt = {i2s_dis_i, fir_done_i, dma_done_i};

	for (genvar gi = 0; gi < IRQ_NUM; gi = gi + 1)
	begin : g_irq
		i2s_dma_irq_bit u_irq_bit (
			.WBs_CLK_i (WBs_CLK_i),
			.WBs_RST_i (WBs_RST_i),
			.set_i     (irq_evt[gi]),
			.sts_wr_i  (wr_irq_sts),
			.sts_bit_i (wbs_dat_i[IRQ_POS[gi]]),
			.en_wr_i   (wr_irq_en),
			.en_bit_i  (wbs_dat_i[IRQ_POS[gi]]),
			.sts_o     (irq_sts_o[IRQ_POS[gi]]),
			.en_o      (irq_en_o[IRQ_POS[gi]])
		);
	end

	// data available is a level with no enable
	assign irq_sts_o[IRQ_DAT_AVL] = dat_avl;
	assign irq_en_o[IRQ_DAT_AVL]  = 1'b0;

	// ------------------------------
	// fifo data and readback
	// ------------------------------
	i2s_dma_fifo_reader u_fifo_reader (
		.WBs_CLK_i       (WBs_CLK_i),
		.WBs_RST_i       (WBs_RST_i),
		.fifo_rd_phase_i (fifo_rd_phase),
		.fifo_empty_i    (fifo_empty_i),
		.fifo_dat_i      (fifo_dat_i),
		.fifo_pop_o      (fifo_pop_o),
		.fifo_word_o     (fifo_word)
	);

	i2s_dma_rd_mux u_rd_mux (
		.wbs_adr_i    (wbs_adr_i),
		.i2s_en_i     (i2s_en_o),
		.fir_en_i     (fir_en_o),
		.fifo_flush_i (fifo_flush_o),
		.dma_en_i     (dma_en),
		.dma_cnt_i    (dma_cnt_o),
		.dma_start_i  (dma_start_o),
		.irq_sts_i    (irq_sts_o),
		.irq_en_i     (irq_en_o),
		.fifo_full_i  (fifo_full_i),
		.fifo_empty_i (fifo_empty_i),
		.fifo_level_i (fifo_level_i),
		.fifo_word_i  (fifo_word),
		.dma_busy_i   (dma_busy_i),
		.dma_active_i (dma_active_i),
		.dma_req_i    (dma_req_i),
		.wbs_dat_o    (wbs_dat_o)
	);

endmodule

// ==== i2s_dma_trace.txt ====
# columns: op sel data expected, all hex
# rd/wr/wrn sel=address; pulse 0 dma_done 1 fir_done 2 i2s_dis 3 dma_clr; level 0 busy 1 active 2 req
# chk sel: 0 i2s_en 1 fir_en 2 dma_start 3 dma_cnt 4 irq_sts 5 irq_en 6 fifo count 7 flush count
rd 000 0 00000000
rd 002 0 00000000
rd 003 0 00000000
rd 004 0 00010000
rd 005 0 00000000
rd 007 0 00000000
rd 008 0 00000000
rd 009 0 00000000
rd 00a 0 00000004
rd 00c 0 00000000
rd 001 0 00000000
rd 3ff 0 00000000
wr 000 1 0
rd 000 0 00000001
chk 0 0 1
wr 00c 1 0
rd 00c 0 00000001
chk 1 0 1
wr 003 f 0
rd 003 0 0000000b
chk 5 0 b
wrn 000 0 0
rd 000 0 00000001
wr 00a 3ff 0
rd 00a 0 000001ff
chk 3 0 1ff
level 0 1 0
level 2 1 0
rd 009 0 00000005
level 0 0 0
level 2 0 0
pulse 0 0 0
pulse 1 0 0
rd 002 0 00000003
pulse 2 0 0
chk 0 0 0
rd 002 0 0000000b
wr 002 a 0
rd 002 0 0000000a
wr 002 0 0
chk 4 0 0
wr 00a 2 0
push 0 1111 0
push 0 2222 0
chk 2 0 0
rd 002 0 00000004
wr 008 1 0
chk 2 0 1
rd 009 0 00000008
pulse 3 0 0
chk 2 0 0
rd 008 0 00000000
rd 005 0 22221111
chk 6 0 0
rd 002 0 00000000
wr 007 1 0
chk 7 0 1
rd 007 0 00000000

// ==== i2s_dma_wb_decode.sv ====
/*
 * Wishbone slave decode for the I2S/DMA registers
 * one-cycle write strobes, fifo read phase, 1 or 2 cycle ack
 */
`timescale 1ns/100ps

module i2s_dma_wb_decode
	import i2s_dma_pkg::*;
(
	input  logic                 WBs_CLK_i,
	input  logic                 WBs_RST_i,
	input  logic [WB_ADR_W-1:0]  wbs_adr_i,
	input  logic                 wbs_cyc_i,
	input  logic                 wbs_stb_i,
	input  logic                 wbs_we_i,
	input  logic [WB_BSTB_W-1:0] wbs_byte_stb_i,
	output logic                 wr_ctrl_o,
	output logic                 wr_irq_sts_o,
	output logic                 wr_irq_en_o,
	output logic                 wr_flush_o,
	output logic                 wr_dma_en_o,
	output logic                 wr_dma_cnt_o,
	output logic                 wr_fir_o,
	output logic                 fifo_rd_phase_o,
	output logic                 wbs_ack_o
);

	// ack and its one-cycle delayed copy
	logic ack_r;
	logic ack_d;
	// first cycle of an access
	logic acc_start;
	logic wr_start;
	// fifo data read in progress
	logic fifo_rd_sel;

	// ------------------------------
	// access qualification
	// ------------------------------
	// nothing pending from this or the previous access
	assign acc_start = wbs_cyc_i & wbs_stb_i & ~ack_r & ~ack_d;
	// only byte lane 0 carries register bits
	assign wr_start  = acc_start & wbs_we_i & wbs_byte_stb_i[0];

	assign wr_ctrl_o    = wr_start & (wbs_adr_i == ADR_CTRL);
	assign wr_irq_sts_o = wr_start & (wbs_adr_i == ADR_IRQ_STS);
	assign wr_irq_en_o  = wr_start & (wbs_adr_i == ADR_IRQ_EN);
	assign wr_flush_o   = wr_start & (wbs_adr_i == ADR_FIFO_FLUSH);
	assign wr_dma_en_o  = wr_start & (wbs_adr_i == ADR_DMA_EN);
	assign wr_dma_cnt_o = wr_start & (wbs_adr_i == ADR_DMA_CNT);
	assign wr_fir_o     = wr_start & (wbs_adr_i == ADR_FIR_CTRL);

	// ------------------------------
	// fifo data read
	// ------------------------------
	assign fifo_rd_sel = wbs_cyc_i & ~wbs_we_i & (wbs_adr_i == ADR_FIFO_DAT);

	// cycles 0 and 1 of the read, ended by the delayed ack
	assign fifo_rd_phase_o = fifo_rd_sel & wbs_stb_i & ~ack_d;

	// slow ack leaves room for two pops
	assign wbs_ack_o = fifo_rd_sel ? ack_d : ack_r;

	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
	begin
		if (WBs_RST_i)
		begin
			ack_r <= 1'b0;
			ack_d <= 1'b0;
		end
		else
		begin
			ack_r <= acc_start;
			ack_d <= ack_r;
		end
	end

endmodule

// ==== tb_i2s_dma_regs.sv ====
/*
 * testbench for the I2S/DMA host register block
 * runs bus, event and fifo operations from the trace file
 * keeps a queue model of the decimated-data fifo
 */
`timescale 1ns/100ps

module tb_i2s_dma_regs
	import i2s_dma_pkg::*;
;

	localparam int DRIVE_DLY   = 1;
	localparam int ACK_TIMEOUT = 20;
	localparam int FIFO_DEPTH  = 256;
	localparam int MAX_LINES   = 500;

	logic                  WBs_CLK_i;
	logic                  WBs_RST_i;
	logic [WB_ADR_W-1:0]   wbs_adr_i;
	logic                  wbs_cyc_i;
	logic                  wbs_stb_i;
	logic                  wbs_we_i;
	logic [WB_BSTB_W-1:0]  wbs_byte_stb_i;
	logic [WB_DAT_W-1:0]   wbs_dat_i;
	logic [WB_DAT_W-1:0]   wbs_dat_o;
	logic                  wbs_ack_o;
	logic                  i2s_dis_i;
	logic                  i2s_en_o;
	logic                  fir_en_o;
	logic                  fir_done_i;
	logic [SAMPLE_W-1:0]   fifo_dat_i;
	logic                  fifo_empty_i;
	logic                  fifo_full_i;
	logic [FIFO_LVL_W-1:0] fifo_level_i;
	logic                  fifo_pop_o;
	logic                  fifo_flush_o;
	logic                  dma_done_i;
	logic                  dma_clr_i;
	logic                  dma_busy_i;
	logic                  dma_active_i;
	logic                  dma_req_i;
	logic                  dma_start_o;
	logic [FIFO_LVL_W-1:0] dma_cnt_o;
	logic [IRQ_W-1:0]      irq_sts_o;
	logic [IRQ_W-1:0]      irq_en_o;

	// fifo model, head at index 0
	logic [SAMPLE_W-1:0] fifo_q [$];
	logic pop_seen;
	logic flush_seen;
	int   flush_cnt;
	int   fd;

	i2s_dma_regs_top u_i2s_dma_regs_top (.*);

	always #5 WBs_CLK_i = ~WBs_CLK_i;

	// ------------------------------
	// checks and fifo model
	// ------------------------------
	task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
		input string what);
		assert (got == expected)
		else
		begin
			$display("FAILED at %0t: %s is %08h, expected %08h", $time, what, got, expected);
			$display("Checks failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// first-word-fall-through view of the queue
	task automatic drive_fifo_ports();
		fifo_level_i = FIFO_LVL_W'(fifo_q.size());
		fifo_empty_i = (fifo_q.size() == 0);
		fifo_full_i  = (fifo_q.size() >= FIFO_DEPTH);
		fifo_dat_i   = (fifo_q.size() == 0) ? '0 : fifo_q[0];
	endtask

	task automatic push_sample(input logic [SAMPLE_W-1:0] smp);
		@(posedge WBs_CLK_i);
		#DRIVE_DLY;
		fifo_q.push_back(smp);
		drive_fifo_ports();
	endtask

	// pop and flush sampled mid-cycle, applied after the edge
	always
	begin
		@(negedge WBs_CLK_i);
		pop_seen   = fifo_pop_o;
		flush_seen = fifo_flush_o;
		if (flush_seen)
			flush_cnt = flush_cnt + 1;
		@(posedge WBs_CLK_i);
		#DRIVE_DLY;
		if (flush_seen)
			fifo_q.delete();
		else if (pop_seen)
		begin
			assert (fifo_q.size() > 0)
			else
			begin
				$display("FAILED at %0t: pop of an empty fifo", $time);
				$display("Checks failed");
				$fatal(1, "fifo underflow");
			end
			void'(fifo_q.pop_front());
		end
		drive_fifo_ports();
	end

	// ------------------------------
	// bus and event drivers
	// ------------------------------
	task automatic bus_access(input logic we, input logic [WB_ADR_W-1:0] adr,
		input logic [WB_DAT_W-1:0] dat, input logic [WB_BSTB_W-1:0] bstb,
		output logic [WB_DAT_W-1:0] rdat);
		int cycles;
		int exp_cycles;
		// fifo data reads take the slow ack
		exp_cycles = (!we && adr == ADR_FIFO_DAT) ? 2 : 1;
		@(posedge WBs_CLK_i);
		#DRIVE_DLY;
		wbs_cyc_i      = 1'b1;
		wbs_stb_i      = 1'b1;
		wbs_we_i       = we;
		wbs_adr_i      = adr;
		wbs_dat_i      = dat;
		wbs_byte_stb_i = bstb;
		cycles = 0;
		@(negedge WBs_CLK_i);
		while (!wbs_ack_o)
		begin
			cycles = cycles + 1;
			if (cycles > ACK_TIMEOUT)
			begin
				$display("bus acknowledge never came for address %03h", adr);
				$display("Checks failed");
				$fatal(1, "bus timeout");
			end
			@(negedge WBs_CLK_i);
		end
		rdat = wbs_dat_o;
		check_value(32'(cycles), 32'(exp_cycles), "ack latency in cycles");
		@(posedge WBs_CLK_i);
		#DRIVE_DLY;
		wbs_cyc_i = 1'b0;
		wbs_stb_i = 1'b0;
		wbs_we_i  = 1'b0;
	endtask

	// 0 dma done, 1 filter done, 2 i2s disable, 3 dma clear
	task automatic pulse_event(input logic [31:0] sel);
		@(posedge WBs_CLK_i);
		#DRIVE_DLY;
		dma_done_i = (sel == 32'd0);
		fir_done_i = (sel == 32'd1);
		i2s_dis_i  = (sel == 32'd2);
		dma_clr_i  = (sel == 32'd3);
		@(posedge WBs_CLK_i);
		#DRIVE_DLY;
		dma_done_i = 1'b0;
		fir_done_i = 1'b0;
		i2s_dis_i  = 1'b0;
		dma_clr_i  = 1'b0;
	endtask

	task automatic set_level(input logic [31:0] sel, input logic val);
		@(posedge WBs_CLK_i);
		#DRIVE_DLY;
		case (sel)
			32'd0: dma_busy_i = val;
			32'd1: dma_active_i = val;
			default: dma_req_i = val;
		endcase
	endtask

	task automatic check_port(input logic [31:0] sel, input logic [31:0] expected);
		logic [31:0] got;
		@(posedge WBs_CLK_i);
		#DRIVE_DLY;
		@(negedge WBs_CLK_i);
		// past the flush counter update at this edge
		#DRIVE_DLY;
		case (sel)
			32'd0: got = 32'(i2s_en_o);
			32'd1: got = 32'(fir_en_o);
			32'd2: got = 32'(dma_start_o);
			32'd3: got = 32'(dma_cnt_o);
			32'd4: got = 32'(irq_sts_o);
			32'd5: got = 32'(irq_en_o);
			32'd6: got = 32'(fifo_q.size());
			default: got = 32'(flush_cnt);
		endcase
		check_value(got, expected, $sformatf("port %0d", sel));
	endtask

	// ------------------------------
	// trace interpreter
	// ------------------------------
	task automatic run_op(input string line);
		logic [63:0] op;
		logic [31:0] sel;
		logic [31:0] dat;
		logic [31:0] expected;
		logic [31:0] got;
		int n;
		op = '0;
		n = $sscanf(line, "%s %h %h %h", op, sel, dat, expected);
		if (n != 4)
		begin
			$display("malformed trace line: %s", line);
			$display("Checks failed");
			$fatal(1, "bad trace");
		end
		else if (op == 64'("wr"))
			bus_access(1'b1, sel[WB_ADR_W-1:0], dat, 4'hf, got);
		// byte lane 0 off
		else if (op == 64'("wrn"))
			bus_access(1'b1, sel[WB_ADR_W-1:0], dat, 4'he, got);
		else if (op == 64'("rd"))
		begin
			bus_access(1'b0, sel[WB_ADR_W-1:0], '0, 4'hf, got);
			check_value(got, expected, $sformatf("read of address %03h", sel[WB_ADR_W-1:0]));
		end
		else if (op == 64'("pulse"))
			pulse_event(sel);
		else if (op == 64'("level"))
			set_level(sel, dat[0]);
		else if (op == 64'("push"))
			push_sample(dat[SAMPLE_W-1:0]);
		else if (op == 64'("chk"))
			check_port(sel, expected);
		else
		begin
			$display("unknown operation in trace line: %s", line);
			$display("Checks failed");
			$fatal(1, "bad trace");
		end
	endtask

	task automatic run_trace();
		string line;
		int lines;
		lines = 0;
		while (!$feof(fd) && lines < MAX_LINES)
		begin
			lines = lines + 1;
			line = "";
			void'($fgets(line, fd));
			// skip blank and comment lines
			if (line.len() > 1 && line.getc(0) != "#")
				run_op(line);
		end
		$fclose(fd);
	endtask

	initial
	begin
		WBs_CLK_i      = 1'b0;
		WBs_RST_i      = 1'b1;
		wbs_adr_i      = '0;
		wbs_cyc_i      = 1'b0;
		wbs_stb_i      = 1'b0;
		wbs_we_i       = 1'b0;
		wbs_byte_stb_i = '0;
		wbs_dat_i      = '0;
		i2s_dis_i      = 1'b0;
		fir_done_i     = 1'b0;
		dma_done_i     = 1'b0;
		dma_clr_i      = 1'b0;
		dma_busy_i     = 1'b0;
		dma_active_i   = 1'b0;
		dma_req_i      = 1'b0;
		flush_cnt      = 0;
		drive_fifo_ports();
		repeat (2) @(posedge WBs_CLK_i);
		#DRIVE_DLY;
		WBs_RST_i = 1'b0;
		fd = $fopen("i2s_dma_trace.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open the trace file i2s_dma_trace.txt");
			$display("Checks failed");
			$fatal(1, "no trace");
		end
		else
		begin
			run_trace();
			@(posedge WBs_CLK_i);
			$display("All checks passed");
			$finish;
		end
	end

endmodule

// ==== verilog.f ====
i2s_dma_pkg.sv
i2s_dma_irq_bit.sv
i2s_dma_wb_decode.sv
i2s_dma_ctrl_regs.sv
i2s_dma_fifo_reader.sv
i2s_dma_rd_mux.sv
i2s_dma_regs_top.sv
tb_i2s_dma_regs.sv
